/* flist.f */
fast_read_pkg.sv
fast_read_if.sv
fast_read_seq.sv
bank_capture.sv
sample_serializer.sv
fast_read_top.sv
tb_fast_read_asserts.sv
tb_fast_read.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fast_read
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_fast_read.sv */
`timescale 1ns/1ps

module tb_fast_read;
    import fast_read_pkg::*;

    localparam int NUM_ROWS   = 6;
    localparam int CLK_HALF   = 4;
    localparam int TAIL_TICKS = 2;
    localparam int MAX_GAP    = 4;
    localparam int NUM_ADDR   = 1 << ADDR_W;
    localparam int TAG_W      = WORD_W - ADDR_W - BANK_W;

    logic       clk;
    logic       rstn;
    logic       sample_tick;
    logic       fast_read_en;
    logic       capture_start;
    logic       path96_en;
    pkt_len_e   pkt_data_length;
    idle_len_t  pkt_idle_length;
    bank_word_t fast_din [NUM_BANKS];
    chip_en_t   fast_chip_en;
    mem_addr_t  fast_addr;
    logic       fast_rd_done;
    sample_t    adc_data;
    logic       adc_data_valid;

    // Stimulus table, one read per row
    logic      row_path96 [NUM_ROWS];
    pkt_len_e  row_len    [NUM_ROWS];
    idle_len_t row_idle   [NUM_ROWS];
    int        row_gap    [NUM_ROWS];

    logic [TAG_W-1:0] tag;
    logic             exp_valid [$];
    sample_t          exp_data  [$];
    int               exp_burst [$];
    logic [1:0]       tick_hist;
    int               run_len;
    logic             done_ok;
    longint           limit_ns;

    fast_read_top u_fast_read_top (
        .clk             (clk),
        .rstn            (rstn),
        .sample_tick     (sample_tick),
        .fast_read_en    (fast_read_en),
        .capture_start   (capture_start),
        .path96_en       (path96_en),
        .pkt_data_length (pkt_data_length),
        .pkt_idle_length (pkt_idle_length),
        .fast_din        (fast_din),
        .fast_chip_en    (fast_chip_en),
        .fast_addr       (fast_addr),
        .fast_rd_done    (fast_rd_done),
        .adc_data        (adc_data),
        .adc_data_valid  (adc_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Memory model, drives a bank only while it is enabled
    always_comb begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            if (fast_chip_en[k]) begin
                fast_din[k] = {fast_addr, bank_idx_t'(k), tag};
            end else begin
                fast_din[k] = '0;
            end
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s got=%h exp=%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s got=%h exp=%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s got=%h exp=%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("mismatch %s got=%h exp=%h", name, got, exp));
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic int addrs_per_pkt(input int r);
        return (row_idle[r] == '0) ? NUM_ADDR : (2 << int'(row_len[r]));
    endfunction

    function automatic int row_ticks(input int r);
        int nb;
        int pkts;
        nb   = row_path96[r] ? NUM_BANKS : HALF_BANKS;
        pkts = NUM_ADDR / addrs_per_pkt(r);
        return 1 + NUM_ADDR * 2 * nb + int'(row_idle[r]) * (pkts - 1);
    endfunction

    task automatic push_sample(input logic v, input sample_t d);
        exp_valid.push_back(v);
        exp_data.push_back(d);
    endtask

    task automatic build_expected(input int r);
        int         nb;
        int         per_pkt;
        bank_word_t w;
        nb      = row_path96[r] ? NUM_BANKS : HALF_BANKS;
        per_pkt = addrs_per_pkt(r);
        // Start tick only fetches bank 0
        push_sample(1'b0, '0);
        for (int a = 0; a < NUM_ADDR; a++) begin
            for (int b = 0; b < nb; b++) begin
                w = {mem_addr_t'(a), bank_idx_t'(b), tag};
                push_sample(1'b1, w[WORD_W-1:SAMPLE_W]);
                push_sample(1'b1, w[SAMPLE_W-1:0]);
            end
            if ((a % per_pkt) == per_pkt - 1) begin
                exp_burst.push_back(per_pkt * 2 * nb);
                if (a != NUM_ADDR - 1) begin
                    repeat (int'(row_idle[r])) push_sample(1'b0, '0);
                end
            end
        end
        repeat (TAIL_TICKS) push_sample(1'b0, '0);
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    task automatic check_output();
        logic    v;
        sample_t d;
        if (exp_valid.size() == 0) begin
            fail_run("Output sampled after a tick with no expected value left");
        end
        v = exp_valid.pop_front();
        d = exp_data.pop_front();
        check_flag("adc_data_valid", adc_data_valid, v);
        check_sample("adc_data", adc_data, d);
        if (v) begin
            run_len++;
        end else if (run_len > 0) begin
            if (exp_burst.size() == 0) begin
                fail_run("Valid burst ended with no expected burst left");
            end
            check_count("burst length", run_len, exp_burst.pop_front());
            run_len = 0;
        end
    endtask

    // Output settles two cycles after the tick cycle
    always @(negedge clk) begin
        if (tick_hist[1]) begin
            check_output();
        end
        if (rstn && !path96_en) begin
            check_flag("fast_chip_en upper banks", |(fast_chip_en >> HALF_BANKS), 1'b0);
        end
        if (rstn && !done_ok) begin
            check_flag("fast_rd_done", fast_rd_done, 1'b0);
        end
        tick_hist <= {tick_hist[0], sample_tick};
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic drive_tick(input int gap);
        sample_tick <= 1'b1;
        @(posedge clk);
        sample_tick <= 1'b0;
        repeat (gap - 1) @(posedge clk);
    endtask

    task automatic run_row(input int r);
        int n_ticks;
        int waited;
        @(posedge clk);
        path96_en       <= row_path96[r];
        pkt_data_length <= row_len[r];
        pkt_idle_length <= row_idle[r];
        fast_read_en    <= 1'b1;
        capture_start   <= 1'b1;
        @(posedge clk);
        capture_start <= 1'b0;
        @(negedge clk);
        check_flag("fast_rd_done", fast_rd_done, 1'b0);
        check_addr("fast_addr", fast_addr, '0);
        done_ok = 1'b0;
        n_ticks = row_ticks(r);
        build_expected(r);
        @(posedge clk);
        repeat (n_ticks - 1) drive_tick(row_gap[r]);
        // Final tick, done may rise from here on
        sample_tick <= 1'b1;
        @(posedge clk);
        sample_tick <= 1'b0;
        done_ok = 1'b1;
        waited  = 0;
        while (!fast_rd_done && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!fast_rd_done) begin
            fail_run("fast_rd_done did not rise after the final tick");
        end
        @(posedge clk);
        repeat (TAIL_TICKS) drive_tick(row_gap[r]);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_count("unseen samples", exp_valid.size(), 0);
        check_count("unseen bursts", exp_burst.size(), 0);
        check_flag("fast_rd_done", fast_rd_done, 1'b1);
        check_addr("fast_addr", fast_addr, '1);
        @(posedge clk);
        fast_read_en <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_addr("fast_addr", fast_addr, '0);
    endtask

    initial begin
        int total;
        void'($urandom(32'h7de8));
        tag = TAG_W'($urandom);

        // path96, packet length, idle ticks, tick gap
        row_path96[0] = 1'b1; row_len[0] = PKT_LEN_4;  row_idle[0] = 0; row_gap[0] = 2;
        row_path96[1] = 1'b1; row_len[1] = PKT_LEN_4;  row_idle[1] = 3; row_gap[1] = 3;
        row_path96[2] = 1'b0; row_len[2] = PKT_LEN_2;  row_idle[2] = 5; row_gap[2] = 4;
        row_path96[3] = 1'b0; row_len[3] = PKT_LEN_8;  row_idle[3] = 0; row_gap[3] = 2;
        row_path96[4] = 1'b1; row_len[4] = PKT_LEN_16; row_idle[4] = 1; row_gap[4] = 2;
        row_path96[5] = 1'b0; row_len[5] = PKT_LEN_8;  row_idle[5] = 2; row_gap[5] = 3;

        rstn            = 1'b0;
        sample_tick     = 1'b0;
        fast_read_en    = 1'b0;
        capture_start   = 1'b0;
        path96_en       = 1'b1;
        pkt_data_length = PKT_LEN_2;
        pkt_idle_length = '0;
        tick_hist       = '0;
        run_len         = 0;
        done_ok         = 1'b0;

        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += row_ticks(r) + TAIL_TICKS + 30;
        end
        limit_ns = longint'(total) * MAX_GAP * 2 * CLK_HALF + 2000;

        fork
            begin
                #(limit_ns);
                $display("Watchdog expired, the run took longer than %0d ns", limit_ns);
                $display("TB FAILED");
                $fatal(1, "timeout");
            end
        join_none

        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_flag("fast_chip_en any", |fast_chip_en, 1'b0);
        check_addr("fast_addr", fast_addr, '0);
        check_flag("fast_rd_done", fast_rd_done, 1'b0);
        check_flag("adc_data_valid", adc_data_valid, 1'b0);
        check_sample("adc_data", adc_data, '0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

/* tb_fast_read_asserts.sv */
`timescale 1ns/1ps

module tb_fast_read_asserts (
    input logic                        clk,
    input logic                        rstn,
    input logic                        path96_en,
    input logic                        capture_start,
    input logic                        fast_rd_done,
    input fast_read_pkg::chip_en_t     fast_chip_en,
    input fast_read_pkg::read_state_e  read_state
);
    import fast_read_pkg::*;

    // ------------------------------
    // Chip enables
    // ------------------------------
    chip_en_onehot: assert property (
        @(posedge clk) disable iff (!rstn) $onehot0(fast_chip_en)
    ) else $error("fast_chip_en enables more than one bank");

    // Narrow path uses the lower banks only
    chip_en_narrow: assert property (
        @(posedge clk) disable iff (!rstn)
        !path96_en |-> ((fast_chip_en >> HALF_BANKS) == '0)
    ) else $error("fast_chip_en drives an upper bank in the narrow path");

    // ------------------------------
    // Done flag
    // ------------------------------
    done_held: assert property (
        @(posedge clk) disable iff (!rstn)
        (fast_rd_done && !capture_start) |=> fast_rd_done
    ) else $error("fast_rd_done dropped without capture_start");

    done_idle: assert property (
        @(posedge clk) disable iff (!rstn)
        fast_rd_done |-> (read_state == READ_IDLE)
    ) else $error("Read left idle while fast_rd_done was high");

endmodule

bind fast_read_seq tb_fast_read_asserts u_fast_read_asserts (
    .clk           (clk),
    .rstn          (rstn),
    .path96_en     (path96_en),
    .capture_start (capture_start),
    .fast_rd_done  (fast_rd_done),
    .fast_chip_en  (fast_chip_en),
    .read_state    (read_state)
);

/* fast_read_top.sv */
`timescale 1ns/1ps

module fast_read_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      sample_tick,
    input  logic                      fast_read_en,
    input  logic                      capture_start,
    input  logic                      path96_en,
    input  fast_read_pkg::pkt_len_e   pkt_data_length,
    input  fast_read_pkg::idle_len_t  pkt_idle_length,
    input  fast_read_pkg::bank_word_t fast_din [fast_read_pkg::NUM_BANKS],
    output fast_read_pkg::chip_en_t   fast_chip_en,
    output fast_read_pkg::mem_addr_t  fast_addr,
    output logic                      fast_rd_done,
    output fast_read_pkg::sample_t    adc_data,
    output logic                      adc_data_valid
);
    import fast_read_pkg::*;

    bank_word_t word;
    logic       word_new;

    fast_read_if u_cmd_if ();

    // ------------------------------
    // Sequencer
    // ------------------------------
    fast_read_seq u_fast_read_seq (
        .clk             (clk),
        .rstn            (rstn),
        .sample_tick     (sample_tick),
        .fast_read_en    (fast_read_en),
        .capture_start   (capture_start),
        .path96_en       (path96_en),
        .pkt_data_length (pkt_data_length),
        .pkt_idle_length (pkt_idle_length),
        .fast_chip_en    (fast_chip_en),
        .fast_addr       (fast_addr),
        .fast_rd_done    (fast_rd_done),
        .cmd             (u_cmd_if.seq)
    );

    // Bank word capture
    bank_capture u_bank_capture (
        .clk      (clk),
        .rstn     (rstn),
        .fast_din (fast_din),
        .word     (word),
        .word_new (word_new),
        .cmd      (u_cmd_if.cap)
    );

    // ------------------------------
    // Sample output
    // ------------------------------
    sample_serializer u_sample_serializer (
        .clk            (clk),
        .rstn           (rstn),
        .word           (word),
        .word_new       (word_new),
        .adc_data       (adc_data),
        .adc_data_valid (adc_data_valid),
        .cmd            (u_cmd_if.ser)
    );

endmodule

/* sample_serializer.sv */
`timescale 1ns/1ps

module sample_serializer (
    input  logic                      clk,
    input  logic                      rstn,
    input  fast_read_pkg::bank_word_t word,
    input  logic                      word_new,
    output fast_read_pkg::sample_t    adc_data,
    output logic                      adc_data_valid,
    fast_read_if.ser                  cmd
);
    import fast_read_pkg::*;

    bank_word_t pending;
    logic       sel_hi;

    // Word under output, held across the next capture
    always_ff @(posedge clk) begin
        if (word_new) begin
            pending <= word;
        end
    end

    // ------------------------------
    // Half selection
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            adc_data       <= '0;
            adc_data_valid <= 1'b0;
            sel_hi         <= 1'b1;
        end else if (cmd.tick) begin
            if (cmd.emit) begin
                if (sel_hi) begin
                    adc_data <= pending[WORD_W-1:SAMPLE_W];
                end else begin
                    adc_data <= pending[SAMPLE_W-1:0];
                end
                adc_data_valid <= 1'b1;
                sel_hi         <= !sel_hi;
            end else begin
                // Gap or capture-only tick
                adc_data       <= '0;
                adc_data_valid <= 1'b0;
                sel_hi         <= 1'b1;
            end
        end
    end

endmodule

/* bank_capture.sv */
`timescale 1ns/1ps

module bank_capture (
    input  logic                      clk,
    input  logic                      rstn,
    input  fast_read_pkg::bank_word_t fast_din [fast_read_pkg::NUM_BANKS],
    output fast_read_pkg::bank_word_t word,
    output logic                      word_new,
    fast_read_if.cap                  cmd
);
    import fast_read_pkg::*;

    bank_word_t sel_word;

    // ------------------------------
    // Bank select
    // ------------------------------
    always_comb begin
        sel_word = '0;
        // Index wider than the bank count
        if (int'(cmd.bank) < NUM_BANKS) begin
            sel_word = fast_din[cmd.bank];
        end
    end

    // Memory answers while its chip enable is high
    always_ff @(posedge clk) begin
        if (cmd.capture) begin
            word <= sel_word;
        end
    end

    // Tells the serializer a fresh word is ready
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            word_new <= 1'b0;
        end else begin
            word_new <= cmd.capture;
        end
    end

endmodule

/* fast_read_seq.sv */
`timescale 1ns/1ps

module fast_read_seq (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      sample_tick,
    input  logic                      fast_read_en,
    input  logic                      capture_start,
    input  logic                      path96_en,
    input  fast_read_pkg::pkt_len_e   pkt_data_length,
    input  fast_read_pkg::idle_len_t  pkt_idle_length,
    output fast_read_pkg::chip_en_t   fast_chip_en,
    output fast_read_pkg::mem_addr_t  fast_addr,
    output logic                      fast_rd_done,
    fast_read_if.seq                  cmd
);
    import fast_read_pkg::*;

    read_state_e       read_state;
    pkt_state_e        pkt_state;
    logic [SLOT_W-1:0] slot;
    idle_len_t         idle_cnt;

    // Next slot 0 tick only flushes the low half of the last word
    logic              tail_end;
    logic              tail_final;
    logic              rd_fin;

    logic [SLOT_W-1:0] last_slot;
    mem_addr_t         blk_mask;
    logic              blk_last;
    logic              gap_last;
    logic              start_rd;
    logic              in_read;
    logic              tick_cap;
    logic              tick_emit;
    bank_idx_t         cap_bank;

    // ------------------------------
    // Slot and packet decode
    // ------------------------------
    assign last_slot = path96_en ? SLOT_W'(2 * NUM_BANKS - 1) : SLOT_W'(2 * HALF_BANKS - 1);

    always_comb begin
        case (pkt_data_length)
            PKT_LEN_2:  blk_mask = mem_addr_t'(1);
            PKT_LEN_4:  blk_mask = mem_addr_t'(3);
            PKT_LEN_8:  blk_mask = mem_addr_t'(7);
            PKT_LEN_16: blk_mask = mem_addr_t'(15);
        endcase
    end

    // Address closes its aligned block
    assign blk_last = (fast_addr & blk_mask) == blk_mask;
    assign gap_last = (idle_cnt + 1'b1) == pkt_idle_length;

    assign start_rd = sample_tick && fast_read_en && !fast_rd_done &&
                      (read_state == READ_IDLE);
    assign in_read  = sample_tick && fast_read_en && (read_state != READ_IDLE);

    // Even slots map onto bank slot/2
    assign cap_bank = slot[SLOT_W-1:1];

    always_comb begin
        tick_cap  = 1'b0;
        tick_emit = 1'b0;
        if (start_rd) begin
            tick_cap = 1'b1;
        end else if (in_read) begin
            if (pkt_state == PKT_GAP) begin
                // Last gap tick already fetches bank 0
                tick_cap = gap_last;
            end else begin
                tick_emit = 1'b1;
                tick_cap  = !slot[0] && !tail_end;
            end
        end
    end

    // ------------------------------
    // Per-tick commands
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cmd.tick     <= 1'b0;
            cmd.capture  <= 1'b0;
            cmd.emit     <= 1'b0;
            fast_chip_en <= '0;
        end else begin
            cmd.tick     <= sample_tick;
            cmd.capture  <= tick_cap;
            cmd.emit     <= tick_emit;
            fast_chip_en <= tick_cap ? (chip_en_t'(1) << cap_bank) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (tick_cap) begin
            cmd.bank <= cap_bank;
        end
    end

    // ------------------------------
    // Read and packet FSMs
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            read_state <= READ_IDLE;
            pkt_state  <= PKT_GAP;
            slot       <= '0;
            idle_cnt   <= '0;
            fast_addr  <= '0;
            tail_end   <= 1'b0;
            tail_final <= 1'b0;
            rd_fin     <= 1'b0;
        end else begin
            rd_fin <= 1'b0;
            if (!fast_read_en) begin
                read_state <= READ_IDLE;
                pkt_state  <= PKT_GAP;
                slot       <= '0;
                idle_cnt   <= '0;
                fast_addr  <= '0;
                tail_end   <= 1'b0;
                tail_final <= 1'b0;
            end else if (start_rd) begin
                read_state <= (pkt_idle_length == '0) ? READ_STREAM : READ_PACKET;
                pkt_state  <= PKT_ACTIVE;
                fast_addr  <= '0;
                slot       <= SLOT_W'(1);
            end else if (in_read) begin
                if (pkt_state == PKT_GAP) begin
                    if (gap_last) begin
                        pkt_state <= PKT_ACTIVE;
                        slot      <= SLOT_W'(1);
                        idle_cnt  <= '0;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end else if ((slot == '0) && tail_end) begin
                    tail_end   <= 1'b0;
                    tail_final <= 1'b0;
                    pkt_state  <= PKT_GAP;
                    if (tail_final) begin
                        read_state <= READ_IDLE;
                        rd_fin     <= 1'b1;
                    end
                end else if (slot == last_slot) begin
                    slot <= '0;
                    if (&fast_addr) begin
                        tail_end   <= 1'b1;
                        tail_final <= 1'b1;
                    end else begin
                        fast_addr <= fast_addr + 1'b1;
                        tail_end  <= (read_state == READ_PACKET) && blk_last;
                    end
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    // Done rises together with the final sample
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fast_rd_done <= 1'b0;
        end else if (rd_fin) begin
            fast_rd_done <= 1'b1;
        end else if ((read_state == READ_IDLE) && capture_start) begin
            fast_rd_done <= 1'b0;
        end
    end

endmodule

/* fast_read_if.sv */
`timescale 1ns/1ps

interface fast_read_if;
    import fast_read_pkg::*;

    // Registered copy of sample_tick
    logic      tick;

    // Load the selected bank word
    logic      capture;
    bank_idx_t bank;

    // A sample leaves on this tick
    logic      emit;

    modport seq (
        output tick,
        output capture,
        output bank,
        output emit
    );

    modport cap (
        input capture,
        input bank
    );

    modport ser (
        input tick,
        input emit
    );

endinterface

/* fast_read_pkg.sv */
package fast_read_pkg;

    // ------------------------------
    // Memory geometry
    // ------------------------------
    localparam int NUM_BANKS  = 24;
    localparam int HALF_BANKS = 12;
    localparam int WORD_W     = 36;
    localparam int SAMPLE_W   = 18;
    localparam int ADDR_W     = 5;

    // Counter widths
    localparam int IDLE_W = 16;
    localparam int SLOT_W = 6;
    localparam int BANK_W = 5;

    // ------------------------------
    // Data types
    // ------------------------------
    typedef logic [WORD_W-1:0]    bank_word_t;
    typedef logic [SAMPLE_W-1:0]  sample_t;
    typedef logic [ADDR_W-1:0]    mem_addr_t;
    typedef logic [IDLE_W-1:0]    idle_len_t;
    typedef logic [BANK_W-1:0]    bank_idx_t;
    typedef logic [NUM_BANKS-1:0] chip_en_t;

    // Addresses per packet
    typedef enum logic [1:0] {
        PKT_LEN_2,
        PKT_LEN_4,
        PKT_LEN_8,
        PKT_LEN_16
    } pkt_len_e;

    // Stream is one packet over all addresses
    typedef enum logic [1:0] {
        READ_IDLE,
        READ_STREAM,
        READ_PACKET
    } read_state_e;

    typedef enum logic {
        PKT_GAP,
        PKT_ACTIVE
    } pkt_state_e;

endpackage
